// File: include/clic_settings.svh
// ----------------------------------------------------------
// Build settings for the CLIC interrupt controller core side
// Source count, ID, level and VS-id widths, cause word width
// ----------------------------------------------------------

`ifndef CLIC_SETTINGS_SVH
`define CLIC_SETTINGS_SVH

// Interrupt sources seen by the external CLIC
`define CLIC_NUM_SRC 64

// Interrupt ID width from the source count
`define CLIC_ID_W ($clog2(`CLIC_NUM_SRC))

// Interrupt level and threshold width
`define CLIC_LVL_W 8

// Virtual supervisor id width
`define CLIC_VSID_W 6

// Cause word width of RV32
`define CLIC_XLEN 32

`endif

// File: verilog/clic_pkg.sv
// ----------------------------------------------------------
// Shared types of the CLIC core-side controller
// Vector typedefs, privilege, route and in-flight enums
// ----------------------------------------------------------

`include "clic_settings.svh"

package clic_pkg;

  // ----------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------
  typedef logic [`CLIC_ID_W-1:0]          irq_id_t;   // Interrupt ID
  typedef logic [`CLIC_LVL_W-1:0]         irq_lvl_t;  // Level or threshold
  typedef logic [`CLIC_VSID_W-1:0]        vsid_t;     // Guest id
  typedef logic [(2**`CLIC_VSID_W)-1:0]   hgeie_t;    // One enable per VS-id
  typedef logic [`CLIC_XLEN-1:0]          xlen_t;     // Trap cause word

  // ----------------------------------------------------------
  // Enums
  // ----------------------------------------------------------
  // Privilege encoding as in mstatus.MPP, 2'b10 reserved
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_t;

  // Rule that decides whether the current interrupt is taken
  typedef enum logic [2:0] {
    ROUTE_NONE   = 3'd0,  // Never taken
    ROUTE_ALWAYS = 3'd1,  // Taken whenever valid
    ROUTE_M_LVL  = 3'd2,  // Valid and above M threshold
    ROUTE_S_LVL  = 3'd3,  // Valid and above S threshold
    ROUTE_VS_LVL = 3'd4   // Valid and above VS threshold
  } route_t;

  // Tracking of a request handed to decode
  typedef enum logic {
    IF_IDLE = 1'b0,
    IF_BUSY = 1'b1
  } inflight_state_t;

endpackage

// File: verilog/clic_irq_if.sv
// ----------------------------------------------------------
// Interrupt descriptor bundle from the external CLIC
// Modports for threshold, routing and acceptance blocks
// ----------------------------------------------------------

`timescale 1ns/1ps

interface clic_irq_if import clic_pkg::*; ();

  logic      valid;  // Arbitrated interrupt present
  irq_id_t   id;     // Winning source
  irq_lvl_t  level;  // Its level
  priv_lvl_t priv;   // Target privilege mode
  logic      v;      // Virtual interrupt flag
  vsid_t     vsid;   // Target guest

  // Level compare only
  modport thresh_mp (
    input level
  );

  // Privilege and guest information
  modport route_mp (
    input priv,
    input v,
    input vsid
  );

  // Validity and cause fields
  modport accept_mp (
    input valid,
    input id,
    input level
  );

endinterface

// File: verilog/clic_thresh_eval.sv
// ----------------------------------------------------------
// Effective M, S and VS thresholds
// Strict level-above-threshold flags per mode
// ----------------------------------------------------------

`timescale 1ns/1ps

module clic_thresh_eval import clic_pkg::*; (
  clic_irq_if.thresh_mp irq_if,
  input  irq_lvl_t      mintthresh_i,   // Programmed M threshold
  input  irq_lvl_t      sintthresh_i,   // Programmed S threshold
  input  irq_lvl_t      vsintthresh_i,  // Programmed VS threshold
  input  irq_lvl_t      mil_i,          // mintstatus.mil
  input  irq_lvl_t      sil_i,          // mintstatus.sil
  input  irq_lvl_t      vsil_i,         // mintstatus.vsil
  output logic          above_m_o,
  output logic          above_s_o,
  output logic          above_vs_o
);

  // ----------------------------------------------------------
  // Effective thresholds
  // ----------------------------------------------------------
  // A running handler at level L blocks everything at or below L,
  // so the status level acts as a second threshold
  irq_lvl_t eff_m;
  irq_lvl_t eff_s;
  irq_lvl_t eff_vs;

  always_comb begin
    // M mode
    if (mintthresh_i > mil_i) begin
      eff_m = mintthresh_i;
    end else begin
      eff_m = mil_i;
    end
    // S mode
    if (sintthresh_i > sil_i) begin
      eff_s = sintthresh_i;
    end else begin
      eff_s = sil_i;
    end
    // VS mode
    if (vsintthresh_i > vsil_i) begin
      eff_vs = vsintthresh_i;
    end else begin
      eff_vs = vsil_i;
    end
  end

  // ----------------------------------------------------------
  // Level compare
  // ----------------------------------------------------------
  // Equal level does not preempt
  assign above_m_o  = (irq_if.level > eff_m);
  assign above_s_o  = (irq_if.level > eff_s);
  assign above_vs_o = (irq_if.level > eff_vs);

endmodule

// File: verilog/clic_mode_route.sv
// ----------------------------------------------------------
// Routing of the CLIC interrupt by hart privilege and V bit
// Produces the route class and the virtual-interrupt flag
// ----------------------------------------------------------

`timescale 1ns/1ps

module clic_mode_route import clic_pkg::*; (
  clic_irq_if.route_mp irq_if,
  input  priv_lvl_t    priv_lvl_i,  // Current hart privilege
  input  logic         v_i,         // Hart in VS/VU mode
  input  logic         sie_i,       // S-mode global enable
  input  logic         vsie_i,      // VS-mode global enable
  input  logic         sgeie_i,     // Guest external enable from hie
  input  vsid_t        vgein_i,     // Guest currently running
  input  hgeie_t       hgeie_i,     // Per-guest enables
  output route_t       route_o,
  output logic         irq_v_o      // Interrupt goes to the running guest
);

  // ----------------------------------------------------------
  // Descriptor decode
  // ----------------------------------------------------------
  logic irq_is_m;
  logic irq_is_s;
  logic vsid_match;
  logic foreign_en;

  assign irq_is_m   = (irq_if.priv == PRIV_M);
  assign irq_is_s   = (irq_if.priv == PRIV_S);
  assign vsid_match = (irq_if.vsid == vgein_i);
  // Other guest traps to the hypervisor
  assign foreign_en = sgeie_i & hgeie_i[irq_if.vsid];

  // ----------------------------------------------------------
  // Route selection
  // ----------------------------------------------------------
  always_comb begin
    route_o = ROUTE_NONE;
    irq_v_o = 1'b0;
    case (priv_lvl_i)
      PRIV_M: begin
        // Only M interrupts above threshold preempt M mode
        if (irq_is_m) begin
          route_o = ROUTE_M_LVL;
        end
      end
      PRIV_S: begin
        if (irq_is_m) begin
          route_o = ROUTE_ALWAYS;  // Higher mode always wins
        end else if (irq_is_s) begin
          if (v_i) begin
            // Hart runs a guest
            if (irq_if.v) begin
              if (vsid_match) begin
                // Delivered to the running guest
                if (vsie_i) begin
                  route_o = ROUTE_VS_LVL;
                  irq_v_o = 1'b1;
                end
              end else if (foreign_en) begin
                route_o = ROUTE_ALWAYS;  // Trap to hypervisor
              end
            end else begin
              route_o = ROUTE_S_LVL;  // HS sie implied while in VS
            end
          end else begin
            // HS mode ignores virtual interrupts
            if (!irq_if.v && sie_i) begin
              route_o = ROUTE_S_LVL;
            end
          end
        end
      end
      PRIV_U: begin
        // Any enabled higher mode interrupt is taken
        if (irq_is_m || (irq_is_s && sie_i)) begin
          route_o = ROUTE_ALWAYS;
        end
      end
      default: begin
        route_o = ROUTE_NONE;  // Reserved encoding
      end
    endcase
  end

  // Virtual flag only ever accompanies the VS threshold rule
  irq_v_route_a: assert final (!irq_v_o || (route_o == ROUTE_VS_LVL))
    else $error("irq_v_o set outside ROUTE_VS_LVL");

endmodule

// File: verilog/clic_accept_ctrl.sv
// ----------------------------------------------------------
// Interrupt acceptance, cause packing and in-flight tracking
// Kill acknowledge toward the CLIC
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "clic_settings.svh"

module clic_accept_ctrl import clic_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_ni,
  clic_irq_if.accept_mp irq_if,
  input  logic          above_m_i,    // Level above M threshold
  input  logic          above_s_i,    // Level above S threshold
  input  logic          above_vs_i,   // Level above VS threshold
  input  logic          irq_v_i,      // Request targets running guest
  input  logic          irq_ready_i,  // Decode took the interrupt
  input  logic          kill_req_i,   // CLIC wants to withdraw
  input  route_t        route_i,
  output logic          irq_req_o,
  output logic          kill_ack_o,
  output xlen_t         cause_o
);

  // ----------------------------------------------------------
  // Request
  // ----------------------------------------------------------
  logic route_ok;

  always_comb begin
    case (route_i)
      ROUTE_ALWAYS: route_ok = 1'b1;
      ROUTE_M_LVL:  route_ok = above_m_i;
      ROUTE_S_LVL:  route_ok = above_s_i;
      ROUTE_VS_LVL: route_ok = above_vs_i;
      default:      route_ok = 1'b0;
    endcase
  end

  assign irq_req_o = irq_if.valid & route_ok;

  // ----------------------------------------------------------
  // Cause word
  // ----------------------------------------------------------
  // Interrupt bit, level for mintstatus, ID for mcause
  assign cause_o = {1'b1,
                    {(`CLIC_XLEN - `CLIC_LVL_W - 17){1'b0}},
                    irq_if.level,
                    {(16 - `CLIC_ID_W){1'b0}},
                    irq_if.id};

  // ----------------------------------------------------------
  // In-flight tracking
  // ----------------------------------------------------------
  inflight_state_t state_q;
  inflight_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IF_IDLE: if (irq_req_o) state_d = IF_BUSY;  // Inserted into pipeline
      IF_BUSY: if (irq_ready_i || kill_ack_o) state_d = IF_IDLE;
      default: state_d = IF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IF_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Withdraw only when nothing is or gets inserted
  assign kill_ack_o = kill_req_i & (state_q == IF_IDLE) & ~irq_req_o;

  // Assertions
  kill_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == IF_BUSY) |-> !kill_ack_o);
  kill_req_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(kill_ack_o && irq_req_o));
  // A guest request passed the VS compare in the threshold block
  virt_lvl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_req_o && irq_v_i) |-> above_vs_i);

endmodule

// File: verilog/clic_ctrl_top.sv
// ----------------------------------------------------------
// Core-side CLIC controller top level
// Descriptor bundle plus threshold, routing, acceptance
// ----------------------------------------------------------

`timescale 1ns/1ps

module clic_ctrl_top import clic_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Hart state from the CSR file
  input  priv_lvl_t priv_lvl_i,
  input  logic      v_i,
  input  logic      sie_i,
  input  logic      vsie_i,
  input  logic      sgeie_i,
  input  vsid_t     vgein_i,
  input  hgeie_t    hgeie_i,
  input  irq_lvl_t  mintthresh_i,
  input  irq_lvl_t  sintthresh_i,
  input  irq_lvl_t  vsintthresh_i,
  input  irq_lvl_t  mil_i,
  input  irq_lvl_t  sil_i,
  input  irq_lvl_t  vsil_i,
  // CLIC side
  input  logic      irq_valid_i,
  input  logic      irq_ready_i,
  input  irq_id_t   irq_id_i,
  input  irq_lvl_t  irq_level_i,
  input  priv_lvl_t irq_priv_i,
  input  logic      irq_v_i,
  input  vsid_t     irq_vsid_i,
  input  logic      kill_req_i,
  output logic      kill_ack_o,
  // Decode stage side
  output logic      irq_req_o,
  output priv_lvl_t irq_priv_o,
  output logic      irq_v_o,
  output xlen_t     irq_cause_o
);

  // Descriptor bundle
  clic_irq_if irq_if ();

  assign irq_if.valid = irq_valid_i;
  assign irq_if.id    = irq_id_i;
  assign irq_if.level = irq_level_i;
  assign irq_if.priv  = irq_priv_i;
  assign irq_if.v     = irq_v_i;
  assign irq_if.vsid  = irq_vsid_i;

  logic   above_m;
  logic   above_s;
  logic   above_vs;
  route_t route;
  logic   route_v;  // Guest flag from routing

  clic_thresh_eval thresh_eval_inst (
    .irq_if        (irq_if),
    .mintthresh_i  (mintthresh_i),
    .sintthresh_i  (sintthresh_i),
    .vsintthresh_i (vsintthresh_i),
    .mil_i         (mil_i),
    .sil_i         (sil_i),
    .vsil_i        (vsil_i),
    .above_m_o     (above_m),
    .above_s_o     (above_s),
    .above_vs_o    (above_vs)
  );

  clic_mode_route mode_route_inst (
    .irq_if     (irq_if),
    .priv_lvl_i (priv_lvl_i),
    .v_i        (v_i),
    .sie_i      (sie_i),
    .vsie_i     (vsie_i),
    .sgeie_i    (sgeie_i),
    .vgein_i    (vgein_i),
    .hgeie_i    (hgeie_i),
    .route_o    (route),
    .irq_v_o    (route_v)
  );

  clic_accept_ctrl accept_ctrl_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_if      (irq_if),
    .above_m_i   (above_m),
    .above_s_i   (above_s),
    .above_vs_i  (above_vs),
    .irq_v_i     (route_v),
    .irq_ready_i (irq_ready_i),
    .kill_req_i  (kill_req_i),
    .route_i     (route),
    .irq_req_o   (irq_req_o),
    .kill_ack_o  (kill_ack_o),
    .cause_o     (irq_cause_o)
  );

  assign irq_priv_o = irq_if.priv;  // Trap goes to the interrupt's mode
  assign irq_v_o    = route_v;

endmodule

// File: dv/tb_clic_ctrl.sv
// ----------------------------------------------------------
// Testbench for the core-side CLIC controller
// LFSR stimulus, reference model, immediate checks, timeout
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clic_ctrl import clic_pkg::*; ();

  localparam int          NUM_CYCLES     = 2000;              // Random cycles
  localparam int          TIMEOUT_CYCLES = NUM_CYCLES + 100;  // Reset and margin
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;          // x^16+x^14+x^13+x^11+1

  // DUT signals
  logic      clk_i;
  logic      rst_ni;
  priv_lvl_t priv_lvl_i;
  logic      v_i;
  logic      sie_i;
  logic      vsie_i;
  logic      sgeie_i;
  vsid_t     vgein_i;
  hgeie_t    hgeie_i;
  irq_lvl_t  mintthresh_i;
  irq_lvl_t  sintthresh_i;
  irq_lvl_t  vsintthresh_i;
  irq_lvl_t  mil_i;
  irq_lvl_t  sil_i;
  irq_lvl_t  vsil_i;
  logic      irq_valid_i;
  logic      irq_ready_i;
  irq_id_t   irq_id_i;
  irq_lvl_t  irq_level_i;
  priv_lvl_t irq_priv_i;
  logic      irq_v_i;
  vsid_t     irq_vsid_i;
  logic      kill_req_i;
  logic      kill_ack_o;
  logic      irq_req_o;
  priv_lvl_t irq_priv_o;
  logic      irq_v_o;
  xlen_t     irq_cause_o;

  // Model state and expectations
  logic        model_busy;  // Interrupt in flight
  logic        exp_req;
  logic        exp_v;
  logic        exp_kill;
  xlen_t       exp_cause;
  logic [15:0] lfsr;
  int          n_checks;
  int          n_errors;
  int          cycle_cnt;

  clic_ctrl_top clic_ctrl_top_inst (.*);

  // ----------------------------------------------------------
  // Clock and timeout
  // ----------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Random source
  // ----------------------------------------------------------
  // One Galois step per bit taken from the LSB
  function automatic logic next_bit();
    logic out_bit;
    out_bit = lfsr[0];
    lfsr = lfsr >> 1;
    if (out_bit) lfsr = lfsr ^ LFSR_TAPS;
    return out_bit;
  endfunction

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    val = '0;
    for (int i = 0; i < n; i++) val = {val[62:0], next_bit()};
    return val;
  endfunction

  // Half the draws from 0..7 so levels collide often
  function automatic irq_lvl_t draw_level();
    if (next_bit()) return irq_lvl_t'(take_bits(8));
    return irq_lvl_t'(take_bits(3));
  endfunction

  // Legal encodings only with S drawn twice as often
  function automatic priv_lvl_t draw_priv();
    logic [1:0] r;
    r = 2'(take_bits(2));
    case (r)
      2'd0:    return PRIV_U;
      2'd3:    return PRIV_M;
      default: return PRIV_S;
    endcase
  endfunction

  task automatic drive_random();
    priv_lvl_i    = draw_priv();
    v_i           = next_bit();
    sie_i         = next_bit();
    vsie_i        = next_bit();
    sgeie_i       = next_bit();
    vgein_i       = vsid_t'(take_bits(6));
    hgeie_i       = hgeie_t'(take_bits(64));
    mintthresh_i  = draw_level();
    sintthresh_i  = draw_level();
    vsintthresh_i = draw_level();
    mil_i         = draw_level();
    sil_i         = draw_level();
    vsil_i        = draw_level();
    irq_valid_i   = (take_bits(2) != 64'd0);  // Valid three quarters of the time
    irq_ready_i   = next_bit();
    irq_id_i      = irq_id_t'(take_bits(6));
    irq_level_i   = draw_level();
    irq_priv_i    = draw_priv();
    irq_v_i       = next_bit();
    // Own guest about half the time
    if (next_bit()) irq_vsid_i = vgein_i;
    else irq_vsid_i = vsid_t'(take_bits(6));
    kill_req_i    = next_bit();
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic irq_lvl_t max_lvl(input irq_lvl_t a, input irq_lvl_t b);
    return (a > b) ? a : b;
  endfunction

  task automatic compute_model();
    logic abv_m;
    logic abv_s;
    logic abv_vs;
    logic take;
    abv_m  = irq_level_i > max_lvl(mintthresh_i, mil_i);
    abv_s  = irq_level_i > max_lvl(sintthresh_i, sil_i);
    abv_vs = irq_level_i > max_lvl(vsintthresh_i, vsil_i);
    take   = 1'b0;
    exp_v  = 1'b0;
    if (irq_priv_i == PRIV_M) begin
      take = (priv_lvl_i == PRIV_M) ? abv_m : 1'b1;  // Lower modes always yield
    end else if (irq_priv_i == PRIV_S) begin
      if (priv_lvl_i == PRIV_U) begin
        take = sie_i;
      end else if (priv_lvl_i == PRIV_S && !v_i) begin
        take = !irq_v_i && sie_i && abv_s;  // HS mode drops virtual ones
      end else if (priv_lvl_i == PRIV_S) begin
        if (!irq_v_i) take = abv_s;
        else if (irq_vsid_i == vgein_i) begin
          exp_v = vsie_i;
          take  = vsie_i && abv_vs;
        end else take = sgeie_i && hgeie_i[irq_vsid_i];  // Foreign guest
      end
    end
    exp_req   = irq_valid_i && take;
    exp_kill  = kill_req_i && !model_busy && !exp_req;
    exp_cause = {1'b1, 7'd0, irq_level_i, 10'd0, irq_id_i};
  endtask

  // State after the coming edge
  task automatic advance_model();
    if (!model_busy && exp_req) model_busy = 1'b1;
    else if (model_busy && (irq_ready_i || exp_kill)) model_busy = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------
  task automatic check_outputs();
    compute_model();
    n_checks = n_checks + 1;
    assert (irq_req_o === exp_req) else begin
      n_errors = n_errors + 1;
      $display("error %0t: irq_req_o %b, model %b", $time, irq_req_o, exp_req);
    end
    n_checks = n_checks + 1;
    assert (kill_ack_o === exp_kill) else begin
      n_errors = n_errors + 1;
      $display("error %0t: kill_ack_o %b, model %b", $time, kill_ack_o, exp_kill);
    end
    n_checks = n_checks + 1;
    assert (irq_v_o === exp_v) else begin
      n_errors = n_errors + 1;
      $display("error %0t: irq_v_o %b, model %b", $time, irq_v_o, exp_v);
    end
    n_checks = n_checks + 1;
    assert (irq_priv_o === irq_priv_i) else begin
      n_errors = n_errors + 1;
      $display("error %0t: irq_priv_o %0d, descriptor %0d", $time, irq_priv_o, irq_priv_i);
    end
    if (exp_req) begin
      n_checks = n_checks + 1;
      assert (irq_cause_o === exp_cause) else begin
        n_errors = n_errors + 1;
        $display("error %0t: irq_cause_o %h, model %h", $time, irq_cause_o, exp_cause);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    $timeformat(-9, 0, " ns", 0);  // Error times in ns
    lfsr          = 16'd18;  // Seed
    n_checks      = 0;
    n_errors      = 0;
    cycle_cnt     = 0;
    model_busy    = 1'b0;
    rst_ni        = 1'b0;
    priv_lvl_i    = PRIV_U;
    v_i           = 1'b0;
    sie_i         = 1'b0;
    vsie_i        = 1'b0;
    sgeie_i       = 1'b0;
    vgein_i       = '0;
    hgeie_i       = '0;
    mintthresh_i  = '0;
    sintthresh_i  = '0;
    vsintthresh_i = '0;
    mil_i         = '0;
    sil_i         = '0;
    vsil_i        = '0;
    irq_valid_i   = 1'b0;
    irq_ready_i   = 1'b0;
    irq_id_i      = '0;
    irq_level_i   = '0;
    irq_priv_i    = PRIV_U;
    irq_v_i       = 1'b0;
    irq_vsid_i    = '0;
    kill_req_i    = 1'b0;

    repeat (3) @(posedge clk_i);
    #2 rst_ni = 1'b1;
    #8 check_outputs();  // Quiet outputs straight out of reset
    advance_model();

    for (int i = 0; i < NUM_CYCLES; i++) begin
      @(posedge clk_i);
      #2 drive_random();
      #8 check_outputs();  // Mid cycle with inputs settled
      advance_model();
    end

    $display("Closing: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
verilog/clic_pkg.sv
verilog/clic_irq_if.sv
verilog/clic_thresh_eval.sv
verilog/clic_mode_route.sv
verilog/clic_accept_ctrl.sv
verilog/clic_ctrl_top.sv
dv/tb_clic_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CLIC controller testbench with Verilator
set -e

cd "$(dirname "$0")"

# Assertions on, so the checks and RTL properties are live
verilator --binary --assert -j 0 --top-module tb_clic_ctrl -f sim.f

output=$(./obj_dir/Vtb_clic_ctrl 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q '^TB PASSED$'; then
  exit 0
else
  exit 1
fi
